//--- idiv_pkg.sv
`default_nettype none

package idiv_pkg;

  // data width of dividend, divisor, quotient and remainder
  localparam int idiv_width = 32;

  // ---------------------------------------------------------------------------
  // payload structs
  // ---------------------------------------------------------------------------

  // request as presented at the top level
  typedef struct packed {
    logic [idiv_width-1:0] dividend;
    logic [idiv_width-1:0] divisor;
    logic                  signed_div;
  } idiv_req_t;

  // unsigned operand magnitudes, decode to execute
  typedef struct packed {
    logic [idiv_width-1:0] dividend_mag;
    logic [idiv_width-1:0] divisor_mag;
  } idiv_operands_t;

  // sign and corner case flags, decode to result
  typedef struct packed {
    logic neg_quot;
    logic neg_rem;
    logic div_by_zero;
  } idiv_fixup_t;

  // quotient and remainder, raw magnitudes or final signed values
  typedef struct packed {
    logic [idiv_width-1:0] quotient;
    logic [idiv_width-1:0] remainder;
  } idiv_result_t;

  // controller phases
  typedef enum logic [2:0] {
    idiv_idle,
    idiv_decode,
    idiv_busy,
    idiv_fixup,
    idiv_done
  } idiv_state_e;

endpackage

`default_nettype wire

//--- idiv_op_decode.sv
`timescale 1ns/1ps
`default_nettype none

module idiv_op_decode (
  input  wire                     clk_i,
  input  wire                     arst_n_i,
  input  wire                     decode_en_i,
  input  idiv_pkg::idiv_req_t     req_i,
  output idiv_pkg::idiv_operands_t operands_o,
  output idiv_pkg::idiv_fixup_t   fixup_o
);

  localparam int w = idiv_pkg::idiv_width;

  idiv_pkg::idiv_req_t req_r;

  logic dividend_neg;
  logic divisor_neg;
  logic divisor_zero;

  // request is held until the next accept, so the caller may move on
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      req_r <= '0;
    end else if (decode_en_i) begin
      req_r <= req_i;
    end
  end

  // ---------------------------------------------------------------------------
  // operand signs and magnitudes
  // ---------------------------------------------------------------------------

  // msb only counts as a sign in signed mode
  assign dividend_neg = req_r.signed_div & req_r.dividend[w-1];
  assign divisor_neg  = req_r.signed_div & req_r.divisor[w-1];
  assign divisor_zero = ~(|req_r.divisor);

  // most negative value maps onto itself, which is the right unsigned magnitude
  assign operands_o.dividend_mag = dividend_neg ? -req_r.dividend : req_r.dividend;
  assign operands_o.divisor_mag  = divisor_neg  ? -req_r.divisor  : req_r.divisor;

  // ---------------------------------------------------------------------------
  // fixup flags
  // ---------------------------------------------------------------------------

  // quotient stays all ones on divide by zero, so no negation there
  assign fixup_o.neg_quot    = (dividend_neg ^ divisor_neg) & ~divisor_zero;
  // remainder follows the dividend sign
  assign fixup_o.neg_rem     = dividend_neg;
  assign fixup_o.div_by_zero = divisor_zero;

endmodule

`default_nettype wire

//--- idiv_iterate.sv
`timescale 1ns/1ps
`default_nettype none

module idiv_iterate (
  input  wire                      clk_i,
  input  wire                      arst_n_i,
  input  wire                      load_en_i,
  input  wire                      step_en_i,
  input  idiv_pkg::idiv_operands_t operands_i,
  output logic                     last_step_o,
  output idiv_pkg::idiv_result_t   raw_o
);

  localparam int w = idiv_pkg::idiv_width;
  localparam int cnt_width = $clog2(w) + 1;
  localparam logic [cnt_width-1:0] last_cnt = cnt_width'(w - 1);

  // partial remainder, dividend/quotient shift register and divisor
  logic [w:0]   rem_r;
  logic [w-1:0] quot_r;
  logic [w-1:0] divisor_r;

  // number of quotient bits resolved so far
  logic [cnt_width-1:0] cnt_r;

  logic [w:0] shifted;
  logic [w:0] diff;
  logic       diff_neg;

  // ---------------------------------------------------------------------------
  // trial subtraction
  // ---------------------------------------------------------------------------

  // bring down the next dividend bit
  assign shifted  = {rem_r[w-1:0], quot_r[w-1]};
  assign diff     = shifted - {1'b0, divisor_r};
  assign diff_neg = diff[w];

  always_ff @(posedge clk_i) begin
    if (load_en_i) begin
      rem_r     <= '0;
      quot_r    <= operands_i.dividend_mag;
      divisor_r <= operands_i.divisor_mag;
    end else if (step_en_i) begin
      // restoring step, keep the difference only when it did not go negative
      rem_r  <= diff_neg ? shifted : diff;
      quot_r <= {quot_r[w-2:0], ~diff_neg};
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_r <= '0;
    end else if (load_en_i) begin
      cnt_r <= '0;
    end else if (step_en_i) begin
      cnt_r <= cnt_r + 1'b1;
    end
  end

  assign last_step_o = (cnt_r == last_cnt);

  assign raw_o.quotient  = quot_r;
  assign raw_o.remainder = rem_r[w-1:0];

  // ---------------------------------------------------------------------------
  // checks
  // ---------------------------------------------------------------------------

  // the controller must reload before stepping past the last quotient bit
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    step_en_i |-> (cnt_r <= last_cnt))
    else $error("step after final quotient bit without a new load");

  // partial remainder never exceeds the data width between steps
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    step_en_i |=> !rem_r[w])
    else $error("partial remainder overflowed");

endmodule

`default_nettype wire

//--- idiv_control.sv
`timescale 1ns/1ps
`default_nettype none

module idiv_control (
  input  wire  clk_i,
  input  wire  arst_n_i,
  input  wire  v_i,
  input  wire  yumi_i,
  input  wire  last_step_i,
  output logic ready_and_o,
  output logic v_o,
  output logic decode_en_o,
  output logic load_en_o,
  output logic step_en_o,
  output logic fixup_en_o
);

  localparam int w = idiv_pkg::idiv_width;

  idiv_pkg::idiv_state_e state_r;
  idiv_pkg::idiv_state_e state_nxt;

  // ---------------------------------------------------------------------------
  // state machine
  // ---------------------------------------------------------------------------

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_r <= idiv_pkg::idiv_idle;
    end else begin
      state_r <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state_r;
    case (state_r)
      idiv_pkg::idiv_idle:   if (v_i) state_nxt = idiv_pkg::idiv_decode;
      idiv_pkg::idiv_decode: state_nxt = idiv_pkg::idiv_busy;
      // one quotient bit per cycle until the datapath flags the last one
      idiv_pkg::idiv_busy:   if (last_step_i) state_nxt = idiv_pkg::idiv_fixup;
      idiv_pkg::idiv_fixup:  state_nxt = idiv_pkg::idiv_done;
      idiv_pkg::idiv_done:   if (yumi_i) state_nxt = idiv_pkg::idiv_idle;
      default:               state_nxt = idiv_pkg::idiv_idle;
    endcase
  end

  // handshakes
  assign ready_and_o = (state_r == idiv_pkg::idiv_idle);
  assign v_o         = (state_r == idiv_pkg::idiv_done);

  // per phase strobes
  assign decode_en_o = ready_and_o & v_i;
  assign load_en_o   = (state_r == idiv_pkg::idiv_decode);
  assign step_en_o   = (state_r == idiv_pkg::idiv_busy);
  assign fixup_en_o  = (state_r == idiv_pkg::idiv_fixup);

  // ---------------------------------------------------------------------------
  // checks
  // ---------------------------------------------------------------------------

  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $onehot0({decode_en_o, load_en_o, step_en_o, fixup_en_o}))
    else $error("stage strobes overlap");

  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    yumi_i |-> v_o)
    else $error("yumi_i without v_o");

  // datapath counter and busy phase agree on exactly w steps
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    load_en_o |=> (step_en_o && !last_step_i) [*(w-1)] ##1
                  (step_en_o && last_step_i) ##1 fixup_en_o)
    else $error("busy phase did not last idiv_width cycles");

endmodule

`default_nettype wire

//--- idiv_result.sv
`timescale 1ns/1ps
`default_nettype none

module idiv_result (
  input  wire                    clk_i,
  input  wire                    arst_n_i,
  input  wire                    fixup_en_i,
  input  idiv_pkg::idiv_fixup_t  fixup_i,
  input  idiv_pkg::idiv_result_t raw_i,
  output idiv_pkg::idiv_result_t res_o
);

  localparam int w = idiv_pkg::idiv_width;

  logic [w-1:0] quot_fix;
  logic [w-1:0] rem_fix;

  idiv_pkg::idiv_result_t res_r;

  // ---------------------------------------------------------------------------
  // sign fixup
  // ---------------------------------------------------------------------------

  always_comb begin
    // divide by zero arrives as all ones with neg_quot cleared in decode
    if (fixup_i.neg_quot) begin
      quot_fix = -raw_i.quotient;
    end else begin
      quot_fix = raw_i.quotient;
    end

    // remainder takes the sign of the dividend
    if (fixup_i.neg_rem) begin
      rem_fix = -raw_i.remainder;
    end else begin
      rem_fix = raw_i.remainder;
    end
  end

  // held until the next division reaches this stage
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      res_r <= '0;
    end else if (fixup_en_i) begin
      res_r.quotient  <= quot_fix;
      res_r.remainder <= rem_fix;
    end
  end

  assign res_o = res_r;

  // restoring division with a zero divisor already yields all ones
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (fixup_en_i && fixup_i.div_by_zero) |-> (&raw_i.quotient))
    else $error("datapath quotient not all ones on divide by zero");

endmodule

`default_nettype wire

//--- idiv_iterative.sv
`timescale 1ns/1ps
`default_nettype none

module idiv_iterative (
  input  wire                    clk_i,
  input  wire                    arst_n_i,
  input  wire                    v_i,
  output logic                   ready_and_o,
  input  idiv_pkg::idiv_req_t    req_i,
  output logic                   v_o,
  output idiv_pkg::idiv_result_t res_o,
  input  wire                    yumi_i
);

  // stage strobes
  logic decode_en;
  logic load_en;
  logic step_en;
  logic fixup_en;
  logic last_step;

  // inter stage payloads
  idiv_pkg::idiv_operands_t operands;
  idiv_pkg::idiv_fixup_t    fixup;
  idiv_pkg::idiv_result_t   raw;

  idiv_control u_control (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .v_i         (v_i),
    .yumi_i      (yumi_i),
    .last_step_i (last_step),
    .ready_and_o (ready_and_o),
    .v_o         (v_o),
    .decode_en_o (decode_en),
    .load_en_o   (load_en),
    .step_en_o   (step_en),
    .fixup_en_o  (fixup_en)
  );

  idiv_op_decode u_op_decode (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .decode_en_i (decode_en),
    .req_i       (req_i),
    .operands_o  (operands),
    .fixup_o     (fixup)
  );

  idiv_iterate u_iterate (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .load_en_i   (load_en),
    .step_en_i   (step_en),
    .operands_i  (operands),
    .last_step_o (last_step),
    .raw_o       (raw)
  );

  idiv_result u_result (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .fixup_en_i (fixup_en),
    .fixup_i    (fixup),
    .raw_i      (raw),
    .res_o      (res_o)
  );

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int period_ns   = 4,
  parameter int reset_count = 2
) (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(period_ns / 2) clk_o = ~clk_o;
  end

  // release just after an edge so the first active cycle is clean
  initial begin
    arst_n_o = 1'b0;
    repeat (reset_count) @(posedge clk_o);
    #1 arst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

//--- tb_idiv_iterative.sv
`timescale 1ns/1ps
`default_nettype none

module tb_idiv_iterative;

  localparam int w = idiv_pkg::idiv_width;
  localparam int max_requests = 64;
  // each request budgets w+8 cycles, the margin covers reset and back-pressure
  localparam int watchdog_cycles = max_requests * (w + 8) + 200;

  logic                   clk;
  logic                   arst_n;
  logic                   v_i;
  logic                   ready_and_o;
  idiv_pkg::idiv_req_t    req_i;
  logic                   v_o;
  idiv_pkg::idiv_result_t res_o;
  logic                   yumi_i;

  tb_clock_gen #(.period_ns(4), .reset_count(2)) u_clock_gen (
    .clk_o    (clk),
    .arst_n_o (arst_n)
  );

  idiv_iterative u_dut (
    .clk_i       (clk),
    .arst_n_i    (arst_n),
    .v_i         (v_i),
    .ready_and_o (ready_and_o),
    .req_i       (req_i),
    .v_o         (v_o),
    .res_o       (res_o),
    .yumi_i      (yumi_i)
  );

  // --------------------------------------------------------------------------
  // reference model and stimulus helpers
  // --------------------------------------------------------------------------

  function automatic idiv_pkg::idiv_result_t expected_result(input idiv_pkg::idiv_req_t req);
    idiv_pkg::idiv_result_t res;
    logic signed [w-1:0]    sa;
    logic signed [w-1:0]    sb;
    sa = req.dividend;
    sb = req.divisor;
    if (req.divisor == '0) begin
      res.quotient  = '1;
      res.remainder = req.dividend;
    end else if (!req.signed_div) begin
      res.quotient  = req.dividend / req.divisor;
      res.remainder = req.dividend % req.divisor;
    end else if (req.dividend == {1'b1, {(w-1){1'b0}}} && sb == -1) begin
      // signed overflow wraps back to the most negative value
      res.quotient  = req.dividend;
      res.remainder = '0;
    end else begin
      res.quotient  = sa / sb;
      res.remainder = sa % sb;
    end
    return res;
  endfunction

  function automatic idiv_pkg::idiv_req_t make_req(input logic [w-1:0] dividend,
                                                   input logic [w-1:0] divisor,
                                                   input logic         signed_div);
    idiv_pkg::idiv_req_t req;
    req.dividend   = dividend;
    req.divisor    = divisor;
    req.signed_div = signed_div;
    return req;
  endfunction

  function automatic idiv_pkg::idiv_req_t random_req(input logic signed_div);
    return make_req($urandom, $urandom, signed_div);
  endfunction

  task automatic wait_cycle();
    @(posedge clk);
    #1;
  endtask

  // --------------------------------------------------------------------------
  // compare tasks
  // --------------------------------------------------------------------------

  task automatic compare_result(input string name, input idiv_pkg::idiv_result_t exp,
                                input idiv_pkg::idiv_result_t act);
    if (act !== exp) begin
      $display("ERROR at %0t ns: %s expected q=%h r=%h, got q=%h r=%h", $time, name,
               exp.quotient, exp.remainder, act.quotient, act.remainder);
      $display("ERRORS FOUND");
      $fatal(1, "result mismatch");
    end
  endtask

  task automatic compare_level(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERROR at %0t ns: %s expected %b, got %b", $time, name, exp, act);
      $display("ERRORS FOUND");
      $fatal(1, "handshake mismatch");
    end
  endtask

  task automatic compare_count(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("ERROR at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
      $display("ERRORS FOUND");
      $fatal(1, "latency mismatch");
    end
  endtask

  // --------------------------------------------------------------------------
  // one division: accept, wait for v_o, hold, consume
  // --------------------------------------------------------------------------

  task automatic run_division(input idiv_pkg::idiv_req_t req, input int hold_cycles,
                              input bit poke_v);
    idiv_pkg::idiv_result_t exp;
    int                     cycles;
    exp = expected_result(req);
    compare_level("ready_and_o", 1'b1, ready_and_o);
    v_i   = 1'b1;
    req_i = req;
    wait_cycle();
    // accepted on that edge, scramble the request inputs from here on
    v_i    = poke_v;
    req_i  = random_req($urandom % 2);
    cycles = 0;
    while (!v_o && cycles <= w + 2) begin
      compare_level("ready_and_o", 1'b0, ready_and_o);
      wait_cycle();
      cycles++;
      req_i = random_req($urandom % 2);
    end
    compare_level("v_o", 1'b1, v_o);
    compare_count("v_o latency", w + 2, cycles);
    compare_result("res_o", exp, res_o);
    repeat (hold_cycles) begin
      wait_cycle();
      compare_level("v_o", 1'b1, v_o);
      compare_level("ready_and_o", 1'b0, ready_and_o);
      compare_result("res_o", exp, res_o);
      req_i = random_req($urandom % 2);
    end
    v_i    = 1'b0;
    yumi_i = 1'b1;
    wait_cycle();
    yumi_i = 1'b0;
    compare_level("v_o", 1'b0, v_o);
    compare_level("ready_and_o", 1'b1, ready_and_o);
  endtask

  // --------------------------------------------------------------------------
  // directed tests
  // --------------------------------------------------------------------------

  task automatic test_reset_state();
    compare_level("ready_and_o", 1'b1, ready_and_o);
    compare_level("v_o", 1'b0, v_o);
  endtask

  task automatic test_unsigned();
    run_division(make_req(32'd100, 32'd7, 1'b0), 0, 1'b0);
    run_division(make_req(32'd0, 32'd5, 1'b0), 0, 1'b0);
    run_division(make_req(32'd6, 32'd9, 1'b0), 0, 1'b0);
    run_division(make_req(32'hffff_ffff, 32'd1, 1'b0), 0, 1'b0);
    run_division(make_req(32'hffff_ffff, 32'hffff_ffff, 1'b0), 0, 1'b0);
    run_division(make_req(32'h8000_0000, 32'd3, 1'b0), 0, 1'b0);
    repeat (20) run_division(random_req(1'b0), 0, 1'b0);
  endtask

  task automatic test_signed();
    run_division(make_req(32'd100, 32'd7, 1'b1), 0, 1'b0);
    run_division(make_req(-32'sd100, 32'd7, 1'b1), 0, 1'b0);
    run_division(make_req(32'd100, -32'sd7, 1'b1), 0, 1'b0);
    run_division(make_req(-32'sd100, -32'sd7, 1'b1), 0, 1'b0);
    repeat (10) run_division(random_req(1'b1), 0, 1'b0);
  endtask

  task automatic test_corner_cases();
    run_division(make_req(32'd1234, 32'd0, 1'b0), 0, 1'b0);
    run_division(make_req(32'hdead_beef, 32'd0, 1'b0), 0, 1'b0);
    run_division(make_req(32'd1234, 32'd0, 1'b1), 0, 1'b0);
    run_division(make_req(-32'sd1234, 32'd0, 1'b1), 0, 1'b0);
    run_division(make_req(32'h8000_0000, 32'hffff_ffff, 1'b1), 0, 1'b0);
    run_division(make_req(32'h8000_0000, 32'd1, 1'b1), 0, 1'b0);
    run_division(make_req(32'h8000_0000, 32'h8000_0000, 1'b1), 0, 1'b0);
  endtask

  // v_i held high through busy and done must not start a second division
  task automatic test_back_pressure();
    repeat (5) run_division(random_req($urandom % 2), 1 + ($urandom % 16), 1'b1);
  endtask

  task automatic test_back_to_back();
    repeat (8) run_division(random_req($urandom % 2), 0, 1'b0);
  endtask

  // --------------------------------------------------------------------------
  // main sequence and watchdog
  // --------------------------------------------------------------------------

  initial begin
    v_i    = 1'b0;
    yumi_i = 1'b0;
    req_i  = '0;
    void'($urandom(32'hf337));
    wait (arst_n === 1'b1);
    wait_cycle();
    test_reset_state();
    test_unsigned();
    test_signed();
    test_corner_cases();
    test_back_pressure();
    test_back_to_back();
    $display("NO ERRORS");
    $finish;
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("timeout: divider did not finish all requests within %0d cycles",
             watchdog_cycles);
    $display("ERRORS FOUND");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

//--- idiv_iterative.f
idiv_pkg.sv
idiv_op_decode.sv
idiv_iterate.sv
idiv_control.sv
idiv_result.sv
idiv_iterative.sv
tb_clock_gen.sv
tb_idiv_iterative.sv
